// File: hw/cache_bridge.sv
////////////////////////////////////////
// memory command to cache bridge top
// packet steering and handshake gating
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module cache_bridge (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // command port
  input  logic                         cmd_v_i,
  input  cache_bridge_pkg::mem_msg_e   cmd_type_i,
  input  cache_bridge_pkg::msg_size_e  cmd_size_i,
  input  logic [`ADDR_WIDTH-1:0]       cmd_addr_i,
  input  logic [`DATA_WIDTH-1:0]       cmd_data_i,
  output logic                         cmd_ready_o,
  // response port
  output logic                         resp_v_o,
  output cache_bridge_pkg::mem_msg_e   resp_type_o,
  output cache_bridge_pkg::msg_size_e  resp_size_o,
  output logic [`ADDR_WIDTH-1:0]       resp_addr_o,
  output logic [`DATA_WIDTH-1:0]       resp_data_o,
  input  logic                         resp_ready_i,
  // cache port
  output logic                         cache_pkt_v_o,
  output cache_bridge_pkg::cache_op_e  cache_op_o,
  output logic [`CACHE_ADDR_WIDTH-1:0] cache_addr_o,
  output logic [`DATA_WIDTH-1:0]       cache_data_o,
  output logic [`DATA_BYTES-1:0]       cache_mask_o,
  input  logic                         cache_pkt_ready_i,
  input  logic [`DATA_WIDTH-1:0]       cache_data_i,
  input  logic                         cache_v_i,
  output logic                         cache_yumi_o
);
  import cache_bridge_pkg::*;

  logic                         init_done;
  logic                         clear_v;
  logic [`CACHE_ADDR_WIDTH-1:0] clear_addr;
  cache_op_e                    enc_op;
  logic [`CACHE_ADDR_WIDTH-1:0] enc_addr;
  logic [`DATA_WIDTH-1:0]       enc_data;
  logic [`DATA_BYTES-1:0]       enc_mask;
  logic                         q_full;
  logic                         q_empty;
  logic                         cmd_take;
  logic                         resp_take;

  tag_clear_seq clear0 (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .cache_pkt_ready_i (cache_pkt_ready_i),
    .cache_v_i         (cache_v_i),
    .clear_v_o         (clear_v),
    .clear_addr_o      (clear_addr),
    .init_done_o       (init_done)
  );

  cmd_encode enc0 (
    .cmd_type_i (cmd_type_i),
    .cmd_size_i (cmd_size_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .op_o       (enc_op),
    .addr_o     (enc_addr),
    .data_o     (enc_data),
    .mask_o     (enc_mask)
  );

  resp_queue rq0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (cmd_take),
    .push_type_i  (cmd_type_i),
    .push_size_i  (cmd_size_i),
    .push_addr_i  (cmd_addr_i),
    .pop_i        (resp_take),
    .cache_data_i (cache_data_i),
    .full_o       (q_full),
    .empty_o      (q_empty),
    .head_type_o  (resp_type_o),
    .head_size_o  (resp_size_o),
    .head_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o)
  );

  // command and packet go together, so a full queue holds back the packet too
  assign cmd_ready_o = init_done && cache_pkt_ready_i && !q_full;
  assign cmd_take    = cmd_v_i && cmd_ready_o;

  // sequencer owns the cache port until the clear is done
  assign cache_pkt_v_o = init_done ? (cmd_v_i && !q_full) : clear_v;
  assign cache_op_o    = init_done ? enc_op : TAGST;
  assign cache_addr_o  = init_done ? enc_addr : clear_addr;
  assign cache_data_o  = init_done ? enc_data : '0;
  assign cache_mask_o  = init_done ? enc_mask : '0;

  assign resp_v_o  = init_done && cache_v_i && !q_empty;
  assign resp_take = resp_v_o && resp_ready_i;

  // TAGST replies are drained here and never reach the response port
  assign cache_yumi_o = resp_take || (!init_done && cache_v_i);

endmodule

`default_nettype wire

// File: hw/cache_bridge_consts.svh
////////////////////////////////////////
// widths, cache geometry, queue depth
// and the CSR map of the cache bridge
////////////////////////////////////////
`ifndef CACHE_BRIDGE_CONSTS_SVH
`define CACHE_BRIDGE_CONSTS_SVH

// data path, same width on both sides
`define DATA_WIDTH 64
`define DATA_BYTES 8
`define ADDR_WIDTH 32
`define CACHE_ADDR_WIDTH 28

// cache geometry
`define L2_SETS 16
`define L2_WAYS 2
`define L2_BLOCKS (`L2_SETS * `L2_WAYS)
`define BLOCK_OFFSET_WIDTH 3
`define LINE_INDEX_WIDTH 5

// commands in flight
`define RESP_QUEUE_DEPTH 4

// anything below the DRAM base is CSR space
`define DRAM_BASE 32'h8000_0000
`define TAGFL_DEV 4'h2

`endif

// File: hw/cache_bridge_pkg.sv
////////////////////////////////////////
// message, size, cache opcode and init
// state enums, slice replication helper
////////////////////////////////////////
`default_nettype none
`include "cache_bridge_consts.svh"

package cache_bridge_pkg;

  typedef enum logic [1:0] {MSG_RD, MSG_WR, MSG_UC_RD, MSG_UC_WR} mem_msg_e;

  // value is log2 of the byte count
  typedef enum logic [1:0] {SIZE_1, SIZE_2, SIZE_4, SIZE_8} msg_size_e;

  typedef enum logic [3:0] {
    LB, LH, LW, LD,
    SB, SH, SW, SD,
    TAGST, TAGFL
  } cache_op_e;

  typedef enum logic [1:0] {INIT_RESET, CLEAR_TAG, READY} init_state_e;

  // repeat the low slice of the given size across the whole bus
  function automatic logic [`DATA_WIDTH-1:0] replicate_slice(
    input logic [`DATA_WIDTH-1:0] data,
    input msg_size_e              size
  );
    logic [`DATA_WIDTH-1:0] rep;
    case (size)
      SIZE_1: rep = {(`DATA_WIDTH/8){data[7:0]}};
      SIZE_2: rep = {(`DATA_WIDTH/16){data[15:0]}};
      SIZE_4: rep = {(`DATA_WIDTH/32){data[31:0]}};
      default: rep = data;
    endcase
    return rep;
  endfunction

endpackage

`default_nettype wire

// File: hw/cmd_encode.sv
////////////////////////////////////////
// command to cache packet translation
// opcode, address, data and byte mask
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module cmd_encode (
  input  cache_bridge_pkg::mem_msg_e   cmd_type_i,
  input  cache_bridge_pkg::msg_size_e  cmd_size_i,
  input  logic [`ADDR_WIDTH-1:0]       cmd_addr_i,
  input  logic [`DATA_WIDTH-1:0]       cmd_data_i,
  output cache_bridge_pkg::cache_op_e  op_o,
  output logic [`CACHE_ADDR_WIDTH-1:0] addr_o,
  output logic [`DATA_WIDTH-1:0]       data_o,
  output logic [`DATA_BYTES-1:0]       mask_o
);
  import cache_bridge_pkg::*;

  localparam int OFF_W = $clog2(`DATA_BYTES);
  localparam int PAD_W = `CACHE_ADDR_WIDTH - `LINE_INDEX_WIDTH - `BLOCK_OFFSET_WIDTH;

  logic             is_write;
  logic             is_flush;
  logic [OFF_W-1:0] byte_off;

  assign is_write = (cmd_type_i == MSG_WR) || (cmd_type_i == MSG_UC_WR);
  // device field is address bits 23:20 in the CSR region
  assign is_flush = (cmd_addr_i < `DRAM_BASE) && (cmd_addr_i[23:20] == `TAGFL_DEV);
  assign byte_off = cmd_addr_i[OFF_W-1:0];

  always_comb
  begin
    case (cmd_size_i)
      SIZE_1:  op_o = is_write ? SB : LB;
      SIZE_2:  op_o = is_write ? SH : LH;
      SIZE_4:  op_o = is_write ? SW : LW;
      default: op_o = is_write ? SD : LD;
    endcase

    addr_o = cmd_addr_i[`CACHE_ADDR_WIDTH-1:0];
    data_o = replicate_slice(cmd_data_i, cmd_size_i);

    // pick the lanes of the addressed slice, offset rounded down to the size
    case (cmd_size_i)
      SIZE_1:
      begin
        mask_o = {{(`DATA_BYTES-1){1'b0}}, 1'b1} << byte_off;
      end
      SIZE_2:
      begin
        mask_o = {{(`DATA_BYTES-2){1'b0}}, 2'b11} << {byte_off[OFF_W-1:1], 1'b0};
      end
      SIZE_4:
      begin
        mask_o = {{(`DATA_BYTES-4){1'b0}}, 4'hf} << {byte_off[OFF_W-1:2], 2'b00};
      end
      default:
      begin
        mask_o = {`DATA_BYTES{1'b1}};
      end
    endcase

    // flush carries its set and way in the low data bits
    if (is_flush)
    begin
      op_o   = TAGFL;
      addr_o = {{PAD_W{1'b0}}, cmd_data_i[`LINE_INDEX_WIDTH-1:0],
                {`BLOCK_OFFSET_WIDTH{1'b0}}};
      data_o = '0;
      mask_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/resp_queue.sv
////////////////////////////////////////
// in-flight header queue and response
// data formation
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module resp_queue (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        push_i,
  input  cache_bridge_pkg::mem_msg_e  push_type_i,
  input  cache_bridge_pkg::msg_size_e push_size_i,
  input  logic [`ADDR_WIDTH-1:0]      push_addr_i,
  input  logic                        pop_i,
  input  logic [`DATA_WIDTH-1:0]      cache_data_i,
  output logic                        full_o,
  output logic                        empty_o,
  output cache_bridge_pkg::mem_msg_e  head_type_o,
  output cache_bridge_pkg::msg_size_e head_size_o,
  output logic [`ADDR_WIDTH-1:0]      head_addr_o,
  output logic [`DATA_WIDTH-1:0]      resp_data_o
);
  import cache_bridge_pkg::*;

  localparam int PTR_W = $clog2(`RESP_QUEUE_DEPTH);
  localparam logic [PTR_W:0] DEPTH = `RESP_QUEUE_DEPTH;

  mem_msg_e               type_q [`RESP_QUEUE_DEPTH];
  msg_size_e              size_q [`RESP_QUEUE_DEPTH];
  logic [`ADDR_WIDTH-1:0] addr_q [`RESP_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;

  assign full_o  = (count_r == DEPTH);
  assign empty_o = (count_r == '0);

  assign head_type_o = type_q[rd_ptr_r];
  assign head_size_o = size_q[rd_ptr_r];
  assign head_addr_o = addr_q[rd_ptr_r];

  // B/H/W/D replies come back at the bottom of the word
  assign resp_data_o = replicate_slice(cache_data_i, head_size_o);

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      type_q[wr_ptr_r] <= push_type_i;
      size_q[wr_ptr_r] <= push_size_i;
      addr_q[wr_ptr_r] <= push_addr_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push_i && !pop_i)
        count_r <= count_r + 1'b1;
      else if (pop_i && !push_i)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/tag_clear_seq.sv
////////////////////////////////////////
// post-reset tag clear sequencer, one
// TAGST per block, counts the replies
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module tag_clear_seq (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         cache_pkt_ready_i,
  input  logic                         cache_v_i,
  output logic                         clear_v_o,
  output logic [`CACHE_ADDR_WIDTH-1:0] clear_addr_o,
  output logic                         init_done_o
);
  import cache_bridge_pkg::*;

  localparam int CNT_W = `LINE_INDEX_WIDTH + 1;
  localparam logic [CNT_W-1:0] BLOCKS = `L2_BLOCKS;
  localparam int PAD_W = `CACHE_ADDR_WIDTH - `LINE_INDEX_WIDTH - `BLOCK_OFFSET_WIDTH;

  init_state_e state_r, state_n;
  logic [CNT_W-1:0] sent_r, sent_n;
  logic [CNT_W-1:0] recv_r, recv_n;

  assign clear_v_o   = (state_r == CLEAR_TAG) && (sent_r != BLOCKS);
  assign init_done_o = (state_r == READY);

  // line index sits just above the block offset
  assign clear_addr_o = {{PAD_W{1'b0}}, sent_r[`LINE_INDEX_WIDTH-1:0],
                         {`BLOCK_OFFSET_WIDTH{1'b0}}};

  always_comb
  begin
    state_n = state_r;
    sent_n  = sent_r;
    recv_n  = recv_r;
    case (state_r)
      INIT_RESET:
      begin
        state_n = CLEAR_TAG;
      end
      CLEAR_TAG:
      begin
        if (clear_v_o && cache_pkt_ready_i)
          sent_n = sent_r + 1'b1;
        if (cache_v_i)
          recv_n = recv_r + 1'b1;
        // every packet sent and every reply drained
        if ((sent_r == BLOCKS) && (recv_r == BLOCKS))
          state_n = READY;
      end
      default:
      begin
        state_n = READY;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= INIT_RESET;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      state_r <= state_n;
      sent_r  <= sent_n;
      recv_r  <= recv_n;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the cache bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache_bridge -f verilog.f -o tb_cache_bridge
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_cache_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: sim/cache_bridge_properties.sv
////////////////////////////////////////
// bound checks on the handshakes and
// the tag clear order
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module cache_bridge_properties (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        cmd_v_i,
  input logic                        cmd_ready_i,
  input logic                        cache_pkt_v_i,
  input logic                        cache_pkt_ready_i,
  input cache_bridge_pkg::cache_op_e cache_op_i,
  input logic                        resp_v_i,
  input logic                        resp_ready_i
);
  import cache_bridge_pkg::*;

  int unsigned tagst_cnt;
  int unsigned in_flight;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tagst_cnt <= 0;
    else if (cache_pkt_v_i && cache_pkt_ready_i && (cache_op_i == TAGST))
      tagst_cnt <= tagst_cnt + 1;
  end

  // commands taken and not yet answered
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      in_flight <= 0;
    else if ((cmd_v_i && cmd_ready_i) && !(resp_v_i && resp_ready_i))
      in_flight <= in_flight + 1;
    else if (!(cmd_v_i && cmd_ready_i) && (resp_v_i && resp_ready_i))
      in_flight <= in_flight - 1;
  end

  ready_after_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_ready_i |-> (tagst_cnt == `L2_BLOCKS))
    else $error("command port opened before every TAGST was sent");

  pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_pkt_v_i && !cache_pkt_ready_i) |=> cache_pkt_v_i)
    else $error("cache packet valid dropped before it was accepted");

  resp_needs_entry: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> (in_flight != 0))
    else $error("response valid with no command in flight");

endmodule

bind cache_bridge cache_bridge_properties props0 (
  .clk_i             (clk_i),
  .reset_i           (reset_i),
  .cmd_v_i           (cmd_v_i),
  .cmd_ready_i       (cmd_ready_o),
  .cache_pkt_v_i     (cache_pkt_v_o),
  .cache_pkt_ready_i (cache_pkt_ready_i),
  .cache_op_i        (cache_op_o),
  .resp_v_i          (resp_v_o),
  .resp_ready_i      (resp_ready_i)
);

`default_nettype wire

// File: sim/cache_model.sv
////////////////////////////////////////
// behavioral cache with byte storage,
// fixed reply delay and stall inputs
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module cache_model #(
  parameter int DELAY = 3
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         pkt_v_i,
  input  cache_bridge_pkg::cache_op_e  op_i,
  input  logic [`CACHE_ADDR_WIDTH-1:0] addr_i,
  input  logic [`DATA_WIDTH-1:0]       data_i,
  input  logic [`DATA_BYTES-1:0]       mask_i,
  output logic                         pkt_ready_o,
  output logic [`DATA_WIDTH-1:0]       data_o,
  output logic                         v_o,
  input  logic                         yumi_i,
  input  logic                         stall_i,
  input  logic                         pkt_stall_i
);
  import cache_bridge_pkg::*;

  logic [7:0]             mem [1024];
  logic [`DATA_WIDTH-1:0] reply_q [$];
  int                     due_q [$];
  int                     cycle = 0;
  int                     nbytes;
  int                     base;
  logic [`DATA_WIDTH-1:0] rdata;

  // packets are refused while the packet stall is high
  assign pkt_ready_o = !pkt_stall_i;

  // same fill as the reference memory of the testbench
  initial
  begin
    for (int i = 0; i < 1024; i++)
      mem[i] = 8'(i ^ (i >> 2));
    v_o    <= 1'b0;
    data_o <= '0;
  end

  always @(posedge clk_i)
  begin
    cycle = cycle + 1;
    if (reset_i)
    begin
      reply_q.delete();
      due_q.delete();
      v_o <= 1'b0;
    end
    else
    begin
      if (pkt_v_i && pkt_ready_o)
      begin
        rdata  = '0;
        nbytes = 0;
        case (op_i)
          LB: nbytes = 1;
          LH: nbytes = 2;
          LW: nbytes = 4;
          LD: nbytes = 8;
          SB, SH, SW, SD:
          begin
            for (int lane = 0; lane < `DATA_BYTES; lane++)
              if (mask_i[lane])
                mem[int'(addr_i[9:3]) * 8 + lane] = data_i[lane*8 +: 8];
          end
          default:
          begin
            // TAGST and TAGFL only get an empty reply
          end
        endcase
        // loads come back at the bottom of the word
        if (nbytes != 0)
        begin
          base = int'(addr_i[9:0]) & ~(nbytes - 1);
          for (int i = 0; i < nbytes; i++)
            rdata[i*8 +: 8] = mem[base + i];
        end
        reply_q.push_back(rdata);
        due_q.push_back(cycle + DELAY);
      end
      // a presented reply is held until it is taken
      if (v_o && yumi_i)
        v_o <= 1'b0;
      else if (!v_o && (reply_q.size() > 0) && (due_q[0] <= cycle) && !stall_i)
      begin
        v_o    <= 1'b1;
        data_o <= reply_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_cache_bridge.sv
////////////////////////////////////////
// cache bridge testbench with stimulus,
// reference model and response compare
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cache_bridge_consts.svh"

module tb_cache_bridge;
  import cache_bridge_pkg::*;

  // 70 for init, 40 commands at up to 60 cycles, plus margin
  localparam int TIMEOUT = 4000;
  localparam int DELAY   = 3;

  logic                         clk_i;
  logic                         reset_i;
  logic                         cmd_v_i;
  mem_msg_e                     cmd_type_i;
  msg_size_e                    cmd_size_i;
  logic [`ADDR_WIDTH-1:0]       cmd_addr_i;
  logic [`DATA_WIDTH-1:0]       cmd_data_i;
  logic                         cmd_ready_o;
  logic                         resp_v_o;
  mem_msg_e                     resp_type_o;
  msg_size_e                    resp_size_o;
  logic [`ADDR_WIDTH-1:0]       resp_addr_o;
  logic [`DATA_WIDTH-1:0]       resp_data_o;
  logic                         resp_ready_i;
  logic                         cache_pkt_v_o;
  cache_op_e                    cache_op_o;
  logic [`CACHE_ADDR_WIDTH-1:0] cache_addr_o;
  logic [`DATA_WIDTH-1:0]       cache_data_o;
  logic [`DATA_BYTES-1:0]       cache_mask_o;
  logic                         cache_pkt_ready_i;
  logic [`DATA_WIDTH-1:0]       cache_data_i;
  logic                         cache_v_i;
  logic                         cache_yumi_o;
  logic                         cache_stall;
  logic                         pkt_stall;

  logic [7:0]             ref_mem [1024];
  string                  exp_name_q [$];
  mem_msg_e               exp_type_q [$];
  msg_size_e              exp_size_q [$];
  logic [`ADDR_WIDTH-1:0] exp_addr_q [$];
  logic [`DATA_WIDTH-1:0] exp_data_q [$];
  logic [`ADDR_WIDTH-1:0] addr_list [16];
  msg_size_e              size_list [16];
  integer                 seed;
  string                  cmp_name;
  int err_cnt = 0;
  int check_cnt = 0;
  int sent_cnt = 0;
  int resp_cnt = 0;
  int cycle_cnt = 0;
  int tagst_cnt = 0;
  int tagst_reply_cnt = 0;
  logic init_seen = 1'b0;

  cache_bridge dut0 (.*);

  cache_model #(.DELAY(DELAY)) cache0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pkt_v_i     (cache_pkt_v_o),
    .op_i        (cache_op_o),
    .addr_i      (cache_addr_o),
    .data_i      (cache_data_o),
    .mask_i      (cache_mask_o),
    .pkt_ready_o (cache_pkt_ready_i),
    .data_o      (cache_data_i),
    .v_o         (cache_v_i),
    .yumi_i      (cache_yumi_o),
    .stall_i     (cache_stall),
    .pkt_stall_i (pkt_stall)
  );

  initial
    clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Something failed");
      $finish;
    end
  end

  function automatic int slice_bytes(input msg_size_e size);
    return 1 << int'(size);
  endfunction

  // first byte of the slice with the offset rounded down to the size
  function automatic int slice_base(input logic [`ADDR_WIDTH-1:0] addr, input msg_size_e size);
    return int'(addr[9:0]) & ~(slice_bytes(size) - 1);
  endfunction

  function automatic logic is_flush_addr(input logic [`ADDR_WIDTH-1:0] addr);
    return (addr < `DRAM_BASE) && (addr[23:20] == `TAGFL_DEV);
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] repeat_slice(input logic [`DATA_WIDTH-1:0] data,
                                                          input msg_size_e size);
    logic [`DATA_WIDTH-1:0] rep;
    for (int i = 0; i < `DATA_BYTES; i++)
      rep[i*8 +: 8] = data[(i % slice_bytes(size))*8 +: 8];
    return rep;
  endfunction

  function automatic logic [`DATA_BYTES-1:0] expect_mask(input logic [`ADDR_WIDTH-1:0] addr,
                                                         input msg_size_e size);
    logic [`DATA_BYTES-1:0] mask;
    int lo;
    lo = int'(addr[2:0]) & ~(slice_bytes(size) - 1);
    for (int i = 0; i < `DATA_BYTES; i++)
      mask[i] = (i >= lo) && (i < lo + slice_bytes(size));
    return mask;
  endfunction

  function automatic cache_op_e expect_op(input mem_msg_e typ, input logic [`ADDR_WIDTH-1:0] addr,
                                          input msg_size_e size);
    logic is_wr;
    is_wr = (typ == MSG_WR) || (typ == MSG_UC_WR);
    if (is_flush_addr(addr))
      return TAGFL;
    case (size)
      SIZE_1:  return is_wr ? SB : LB;
      SIZE_2:  return is_wr ? SH : LH;
      SIZE_4:  return is_wr ? SW : LW;
      default: return is_wr ? SD : LD;
    endcase
  endfunction

  // stores and flushes are answered with zero data
  function automatic logic [`DATA_WIDTH-1:0] expect_resp(input mem_msg_e typ,
                                                         input logic [`ADDR_WIDTH-1:0] addr,
                                                         input msg_size_e size);
    logic [`DATA_WIDTH-1:0] slice;
    slice = '0;
    if ((typ == MSG_WR) || (typ == MSG_UC_WR))
      return '0;
    for (int i = 0; i < slice_bytes(size); i++)
      slice[i*8 +: 8] = ref_mem[slice_base(addr, size) + i];
    return repeat_slice(slice, size);
  endfunction

  task automatic check_eq(input string name, input string field,
                          input logic [63:0] exp, input logic [63:0] act);
    check_cnt = check_cnt + 1;
    assert (act === exp)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic send_cmd(input string name, input mem_msg_e typ, input msg_size_e size,
                          input logic [`ADDR_WIDTH-1:0] addr, input logic [`DATA_WIDTH-1:0] data);
    logic is_wr;
    logic flush;
    is_wr = (typ == MSG_WR) || (typ == MSG_UC_WR);
    flush = is_flush_addr(addr);
    @(posedge clk_i);
    cmd_v_i    <= 1'b1;
    cmd_type_i <= typ;
    cmd_size_i <= size;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    exp_name_q.push_back(name);
    exp_type_q.push_back(typ);
    exp_size_q.push_back(size);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(expect_resp(typ, addr, size));
    if (is_wr && !flush)
      for (int i = 0; i < slice_bytes(size); i++)
        ref_mem[slice_base(addr, size) + i] = data[i*8 +: 8];
    @(negedge clk_i);
    while (!cmd_ready_o)
      @(negedge clk_i);
    // packet leaves together with the command
    check_eq(name, "pkt valid", 64'(1'b1), 64'(cache_pkt_v_o));
    check_eq(name, "op", 64'(expect_op(typ, addr, size)), 64'(cache_op_o));
    if (flush)
      check_eq(name, "flush addr",
               64'({data[`LINE_INDEX_WIDTH-1:0], {`BLOCK_OFFSET_WIDTH{1'b0}}}),
               64'(cache_addr_o));
    else
      check_eq(name, "addr", 64'(addr[`CACHE_ADDR_WIDTH-1:0]), 64'(cache_addr_o));
    if (is_wr && !flush)
    begin
      check_eq(name, "store data", repeat_slice(data, size), cache_data_o);
      check_eq(name, "mask", 64'(expect_mask(addr, size)), 64'(cache_mask_o));
    end
    sent_cnt = sent_cnt + 1;
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  task automatic wait_responses();
    while (resp_cnt != sent_cnt)
      @(posedge clk_i);
  endtask

  // tag clear order is checked until the command port opens
  always @(negedge clk_i)
  begin
    if (!reset_i && !init_seen)
    begin
      if (cache_pkt_v_o && cache_pkt_ready_i)
      begin
        check_eq("init", "tagst op", 64'(TAGST), 64'(cache_op_o));
        check_eq("init", "tagst addr", 64'(tagst_cnt * 8), 64'(cache_addr_o));
        tagst_cnt = tagst_cnt + 1;
      end
      if (cache_v_i && cache_yumi_o)
        tagst_reply_cnt = tagst_reply_cnt + 1;
      if (cmd_ready_o)
      begin
        init_seen = 1'b1;
        check_eq("init", "tagst count", 64'(`L2_BLOCKS), 64'(tagst_cnt));
        check_eq("init", "tagst replies", 64'(`L2_BLOCKS), 64'(tagst_reply_cnt));
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (resp_v_o && resp_ready_i)
    begin
      if (exp_name_q.size() == 0)
      begin
        err_cnt = err_cnt + 1;
        $display("a response arrived with no command outstanding");
      end
      else
      begin
        cmp_name = exp_name_q.pop_front();
        check_eq(cmp_name, "resp type", 64'(exp_type_q.pop_front()), 64'(resp_type_o));
        check_eq(cmp_name, "resp size", 64'(exp_size_q.pop_front()), 64'(resp_size_o));
        check_eq(cmp_name, "resp addr", 64'(exp_addr_q.pop_front()), 64'(resp_addr_o));
        check_eq(cmp_name, "resp data", exp_data_q.pop_front(), resp_data_o);
        resp_cnt = resp_cnt + 1;
      end
    end
  end

  initial
  begin
    seed         = 32'h873d;
    reset_i      = 1'b1;
    cmd_v_i      = 1'b0;
    cmd_type_i   = MSG_RD;
    cmd_size_i   = SIZE_1;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b0;
    cache_stall  = 1'b0;
    pkt_stall    = 1'b0;
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = 8'(i ^ (i >> 2));
    repeat (5) @(posedge clk_i);
    reset_i      <= 1'b0;
    resp_ready_i <= 1'b1;
    while (!init_seen)
      @(posedge clk_i);

    // writes of every size and then reads of the same places
    for (int i = 0; i < 16; i++)
    begin
      size_list[i] = msg_size_e'(i[1:0]);
      addr_list[i] = `DRAM_BASE | ($random(seed) & 32'h3ff);
      send_cmd("rand_write", i[2] ? MSG_UC_WR : MSG_WR, size_list[i], addr_list[i],
               {$random(seed), $random(seed)});
    end
    wait_responses();
    for (int i = 0; i < 16; i++)
      send_cmd("rand_read", i[2] ? MSG_UC_RD : MSG_RD, size_list[i], addr_list[i], '0);
    wait_responses();

    // set 10, way 1 through the flush device
    send_cmd("tag_flush", MSG_WR, SIZE_8, 32'h0020_0040, 64'h15);
    wait_responses();

    // the cache refuses packets for a while and the command has to wait
    @(posedge clk_i);
    pkt_stall <= 1'b1;
    fork
      send_cmd("pkt_stall", MSG_RD, size_list[0], addr_list[0], '0);
      begin
        repeat (3) @(negedge clk_i);
        check_eq("pkt_stall", "cmd_ready while refused", 64'(1'b0), 64'(cmd_ready_o));
        check_eq("pkt_stall", "pkt valid while refused", 64'(1'b1), 64'(cache_pkt_v_o));
        @(posedge clk_i);
        pkt_stall <= 1'b0;
      end
    join
    wait_responses();

    // fill the queue with replies stalled and the response port closed
    @(posedge clk_i);
    resp_ready_i <= 1'b0;
    cache_stall  <= 1'b1;
    for (int i = 0; i < `RESP_QUEUE_DEPTH; i++)
      send_cmd("backpressure", MSG_RD, size_list[i+4], addr_list[i+4], '0);
    @(negedge clk_i);
    check_eq("backpressure", "cmd_ready when full", 64'(1'b0), 64'(cmd_ready_o));
    check_eq("backpressure", "resp_v while stalled", 64'(1'b0), 64'(resp_v_o));
    @(posedge clk_i);
    cache_stall <= 1'b0;
    repeat (DELAY + 2) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("backpressure", "resp_v held", 64'(1'b1), 64'(resp_v_o));
    check_eq("backpressure", "cmd_ready held low", 64'(1'b0), 64'(cmd_ready_o));
    @(posedge clk_i);
    resp_ready_i <= 1'b1;
    wait_responses();

    repeat (2) @(posedge clk_i);
    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/cache_bridge_pkg.sv
hw/tag_clear_seq.sv
hw/cmd_encode.sv
hw/resp_queue.sv
hw/cache_bridge.sv
sim/cache_model.sv
sim/cache_bridge_properties.sv
sim/tb_cache_bridge.sv
